// ==== src/fb_pkg.sv ====
package fb_pkg;

  // screen and bus widths.
  localparam int h_width = 12;
  localparam int v_width = 12;
  localparam int pixel_width = 12;
  localparam int axi_addr_width = 20;
  localparam int axi_id_width = 4;

  typedef logic [h_width-1:0] h_coord_t;
  typedef logic [v_width-1:0] v_coord_t;
  typedef logic [pixel_width-1:0] pixel_t;
  typedef logic [axi_addr_width-1:0] fb_index_t; // one pixel per address.
  typedef logic [axi_id_width-1:0] axi_id_t;

  localparam logic [1:0] resp_okay = 2'b00;

  // incoming pixel payload.
  typedef struct packed {
    h_coord_t x;
    v_coord_t y;
    pixel_t   pixel;
  } gfx_pixel_s;

  typedef struct packed {
    logic visible;
  } clip_result_s;

  typedef struct packed {
    fb_index_t index;
    pixel_t    pixel;
  } addr_result_s;

  // send covers both aw and w still open.
  typedef enum logic [1:0] {
    idle,
    send,
    resp
  } writer_state_e;

endpackage

// ==== src/fb_clip.sv ====
module fb_clip
  import fb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         load,
  input  logic         take,
  input  gfx_pixel_s   pixel_in,
  input  h_coord_t     h_visible,
  input  v_coord_t     v_visible,
  output logic         stage_valid,
  output clip_result_s result
);

  logic         x_inside;
  logic         y_inside;
  logic         occupied;
  clip_result_s result_q;

  assign x_inside = pixel_in.x < h_visible;
  assign y_inside = pixel_in.y < v_visible;

  // occupancy of the stage.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occupied <= 1'b0;
    end else if (load) begin
      occupied <= 1'b1; // refill wins over take.
    end else if (take) begin
      occupied <= 1'b0;
    end
  end

  // result held until the next load.
  always_ff @(posedge clk) begin
    if (load) begin
      result_q.visible <= x_inside && y_inside;
    end
  end

  assign stage_valid = occupied;
  assign result      = result_q;

endmodule

// ==== src/fb_addr_gen.sv ====
module fb_addr_gen
  import fb_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         load,
  input  logic         take,
  input  gfx_pixel_s   pixel_in,
  input  h_coord_t     h_visible,
  output logic         stage_valid,
  output addr_result_s result
);

  fb_index_t    row_base;
  fb_index_t    index_next;
  logic         occupied;
  addr_result_s result_q;

  // row-major index, y * width + x.
  assign row_base   = fb_index_t'(pixel_in.y) * fb_index_t'(h_visible);
  assign index_next = row_base + fb_index_t'(pixel_in.x);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occupied <= 1'b0;
    end else if (load) begin
      occupied <= 1'b1;
    end else if (take) begin
      occupied <= 1'b0;
    end
  end

  // index and colour travel together.
  always_ff @(posedge clk) begin
    if (load) begin
      result_q.index <= index_next;
      result_q.pixel <= pixel_in.pixel;
    end
  end

  assign stage_valid = occupied;
  assign result      = result_q;

endmodule

// ==== src/fb_axi_writer.sv ====
module fb_axi_writer
  import fb_pkg::*;
#(
  parameter int      axi_data_width = 16,
  parameter axi_id_t axi_id         = 4'h1
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        stage_valid,
  input  clip_result_s                clip,
  input  addr_result_s                addr,
  output logic                        take,

  output logic                        m_axi_awvalid,
  output fb_index_t                   m_axi_awaddr,
  output axi_id_t                     m_axi_awid,
  output logic [7:0]                  m_axi_awlen,
  output logic [2:0]                  m_axi_awsize,
  output logic [1:0]                  m_axi_awburst,
  input  logic                        m_axi_awready,

  output logic                        m_axi_wvalid,
  output logic [axi_data_width-1:0]   m_axi_wdata,
  output logic [axi_data_width/8-1:0] m_axi_wstrb,
  output logic                        m_axi_wlast,
  input  logic                        m_axi_wready,

  input  logic                        m_axi_bvalid,
  input  axi_id_t                     m_axi_bid,
  input  logic [1:0]                  m_axi_bresp,
  output logic                        m_axi_bready,

  output logic                        resp_error
);

  localparam logic [2:0] aw_size = 3'($clog2(axi_data_width / 8));

  writer_state_e             state;
  logic                      start_write;
  logic                      aw_done;
  logic                      w_done;
  logic                      resp_bad;
  fb_index_t                 awaddr_q;
  logic [axi_data_width-1:0] wdata_q;

  // a response handshake frees the writer in the same cycle.
  assign take = stage_valid &&
                (state == idle || (state == resp && m_axi_bvalid));
  assign start_write = take && clip.visible; // off-screen entries just drop.

  // channel closes now or already closed.
  assign aw_done  = !m_axi_awvalid || m_axi_awready;
  assign w_done   = !m_axi_wvalid || m_axi_wready;
  assign resp_bad = (m_axi_bresp != resp_okay) || (m_axi_bid != axi_id);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= idle;
      m_axi_awvalid <= 1'b0;
      m_axi_wvalid  <= 1'b0;
      resp_error    <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (start_write) begin
            m_axi_awvalid <= 1'b1;
            m_axi_wvalid  <= 1'b1;
            state         <= send;
          end
        end
        send: begin
          if (m_axi_awready) m_axi_awvalid <= 1'b0;
          if (m_axi_wready) m_axi_wvalid <= 1'b0;
          if (aw_done && w_done) begin
            state <= resp;
          end
        end
        resp: begin
          if (m_axi_bvalid) begin
            if (resp_bad) resp_error <= 1'b1; // sticky.
            if (start_write) begin
              m_axi_awvalid <= 1'b1;
              m_axi_wvalid  <= 1'b1;
              state         <= send;
            end else begin
              state <= idle;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // payload loads only with a new write, stable while valid.
  always_ff @(posedge clk) begin
    if (start_write) begin
      awaddr_q <= addr.index;
      wdata_q  <= axi_data_width'(addr.pixel);
    end
  end

  assign m_axi_awaddr  = awaddr_q;
  assign m_axi_awid    = axi_id;
  assign m_axi_awlen   = 8'd0;
  assign m_axi_awsize  = aw_size;
  assign m_axi_awburst = 2'b01; // incr.

  assign m_axi_wdata = wdata_q;
  assign m_axi_wstrb = '1;
  assign m_axi_wlast = 1'b1;

  assign m_axi_bready = (state == resp);

endmodule

// ==== src/gfx_fb_writer.sv ====
module gfx_fb_writer
  import fb_pkg::*;
#(
  parameter int      axi_data_width = 16,
  parameter axi_id_t axi_id         = 4'h1
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        s_gfx_valid,
  input  gfx_pixel_s                  s_gfx_pixel,
  output logic                        s_gfx_ready,

  input  h_coord_t                    h_visible,
  input  v_coord_t                    v_visible,

  output logic                        m_axi_awvalid,
  output fb_index_t                   m_axi_awaddr,
  output axi_id_t                     m_axi_awid,
  output logic [7:0]                  m_axi_awlen,
  output logic [2:0]                  m_axi_awsize,
  output logic [1:0]                  m_axi_awburst,
  input  logic                        m_axi_awready,

  output logic                        m_axi_wvalid,
  output logic [axi_data_width-1:0]   m_axi_wdata,
  output logic [axi_data_width/8-1:0] m_axi_wstrb,
  output logic                        m_axi_wlast,
  input  logic                        m_axi_wready,

  input  logic                        m_axi_bvalid,
  input  axi_id_t                     m_axi_bid,
  input  logic [1:0]                  m_axi_bresp,
  output logic                        m_axi_bready,

  output logic                        resp_error
);

  logic         stage_load;
  logic         clip_valid;
  logic         addr_valid;
  logic         take;
  clip_result_s clip_res;
  addr_result_s addr_res;

  // both stages fill and drain in lockstep.
  assign s_gfx_ready = !clip_valid || take;
  assign stage_load  = s_gfx_valid && s_gfx_ready;

  fb_clip u_clip (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (stage_load),
    .take       (take),
    .pixel_in   (s_gfx_pixel),
    .h_visible  (h_visible),
    .v_visible  (v_visible),
    .stage_valid(clip_valid),
    .result     (clip_res)
  );

  fb_addr_gen u_addr_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .load       (stage_load),
    .take       (take),
    .pixel_in   (s_gfx_pixel),
    .h_visible  (h_visible),
    .stage_valid(addr_valid),
    .result     (addr_res)
  );

  fb_axi_writer #(
    .axi_data_width(axi_data_width),
    .axi_id        (axi_id)
  ) u_writer (
    .clk          (clk),
    .rst_n        (rst_n),
    .stage_valid  (addr_valid),
    .clip         (clip_res),
    .addr         (addr_res),
    .take         (take),
    .m_axi_awvalid(m_axi_awvalid),
    .m_axi_awaddr (m_axi_awaddr),
    .m_axi_awid   (m_axi_awid),
    .m_axi_awlen  (m_axi_awlen),
    .m_axi_awsize (m_axi_awsize),
    .m_axi_awburst(m_axi_awburst),
    .m_axi_awready(m_axi_awready),
    .m_axi_wvalid (m_axi_wvalid),
    .m_axi_wdata  (m_axi_wdata),
    .m_axi_wstrb  (m_axi_wstrb),
    .m_axi_wlast  (m_axi_wlast),
    .m_axi_wready (m_axi_wready),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bid    (m_axi_bid),
    .m_axi_bresp  (m_axi_bresp),
    .m_axi_bready (m_axi_bready),
    .resp_error   (resp_error)
  );

endmodule

// ==== verification/fb_axi_slave_model.sv ====
module fb_axi_slave_model
  import fb_pkg::*;
#(
  parameter int axi_data_width = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        awvalid,
  input  fb_index_t                   awaddr,
  input  axi_id_t                     awid,
  output logic                        awready,

  input  logic                        wvalid,
  input  logic [axi_data_width-1:0]   wdata,
  output logic                        wready,

  output logic                        bvalid,
  output axi_id_t                     bid,
  output logic [1:0]                  bresp,
  input  logic                        bready,

  input  logic                        err_req,

  output logic                        log_valid,
  output fb_index_t                   log_addr,
  output logic [axi_data_width-1:0]   log_data
);

  localparam logic [1:0] resp_slverr = 2'b10;

  integer                    seed;
  int                        resp_wait;
  logic                      aw_got;
  logic                      w_got;
  logic                      b_done;
  fb_index_t                 addr_q;
  axi_id_t                   id_q;
  logic [axi_data_width-1:0] data_q;

  initial begin
    seed      = 32'h7a58;
    resp_wait = 1;
    aw_got    = 1'b0;
    w_got     = 1'b0;
    b_done    = 1'b0;
    awready   = 1'b0;
    wready    = 1'b0;
    bvalid    = 1'b0;
    bid       = '0;
    bresp     = resp_okay;
    log_valid = 1'b0;
    log_addr  = '0;
    log_data  = '0;
  end

  // sample on the edge, answer one unit later.
  always @(posedge clk) begin
    b_done = 1'b0;
    if (!rst_n) begin
      aw_got = 1'b0;
      w_got  = 1'b0;
    end else begin
      if (awvalid && awready) begin
        aw_got = 1'b1;
        addr_q = awaddr;
        id_q   = awid;
      end
      if (wvalid && wready) begin
        w_got  = 1'b1;
        data_q = wdata;
      end
      b_done = bvalid && bready;
    end
    #1;
    log_valid = 1'b0;
    if (!rst_n) begin
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
    end else begin
      if (b_done) begin
        bvalid    = 1'b0;
        log_valid = 1'b1; // one-cycle log pulse.
        log_addr  = addr_q;
        log_data  = data_q;
        $display("slave write: addr %h data %h resp %h", addr_q, data_q, bresp);
        aw_got    = 1'b0;
        w_got     = 1'b0;
        resp_wait = $random(seed) & 3;
      end else if (aw_got && w_got && !bvalid) begin
        if (resp_wait == 0) begin
          bvalid = 1'b1;
          bid    = id_q;
          bresp  = err_req ? resp_slverr : resp_okay;
        end else begin
          resp_wait = resp_wait - 1;
        end
      end
      // one write at a time, random stalls otherwise.
      awready = !aw_got && (($random(seed) & 3) != 0);
      wready  = !w_got && (($random(seed) & 3) != 0);
    end
  end

endmodule

// ==== verification/gfx_fb_writer_tb.sv ====
module gfx_fb_writer_tb
  import fb_pkg::*;
();

  localparam int      data_width   = 16;
  localparam axi_id_t write_id     = 4'h3;
  localparam int      num_entries  = 12;
  localparam int      reset_cycles = 4;
  localparam int      limit_cycles = reset_cycles + num_entries * 40;

  typedef struct packed {
    h_coord_t x;
    v_coord_t y;
    pixel_t   colour;
    logic     on_screen;
    logic     err;
  } stim_s;

  typedef struct packed {
    fb_index_t             addr;
    logic [data_width-1:0] data;
    logic                  err;
  } expect_s;

  logic                    clk;
  logic                    rst_n;
  logic                    s_gfx_valid;
  gfx_pixel_s              s_gfx_pixel;
  logic                    s_gfx_ready;
  h_coord_t                h_visible;
  v_coord_t                v_visible;
  logic                    m_axi_awvalid;
  fb_index_t               m_axi_awaddr;
  axi_id_t                 m_axi_awid;
  logic [7:0]              m_axi_awlen;
  logic [2:0]              m_axi_awsize;
  logic [1:0]              m_axi_awburst;
  logic                    m_axi_awready;
  logic                    m_axi_wvalid;
  logic [data_width-1:0]   m_axi_wdata;
  logic [data_width/8-1:0] m_axi_wstrb;
  logic                    m_axi_wlast;
  logic                    m_axi_wready;
  logic                    m_axi_bvalid;
  axi_id_t                 m_axi_bid;
  logic [1:0]              m_axi_bresp;
  logic                    m_axi_bready;
  logic                    resp_error;
  logic                    err_req;
  logic                    log_valid;
  fb_index_t               log_addr;
  logic [data_width-1:0]   log_data;

  stim_s                 stim [num_entries];
  expect_s               exp_q [$];
  expect_s               head;
  int                    errors;
  logic                  err_so_far;
  logic                  err_expected;
  logic                  aw_wait;
  logic                  w_wait;
  fb_index_t             aw_held;
  logic [data_width-1:0] w_held;

  gfx_fb_writer #(
    .axi_data_width(data_width),
    .axi_id        (write_id)
  ) uut (.*);

  fb_axi_slave_model #(
    .axi_data_width(data_width)
  ) axi_slave (
    .clk      (clk),
    .rst_n    (rst_n),
    .awvalid  (m_axi_awvalid),
    .awaddr   (m_axi_awaddr),
    .awid     (m_axi_awid),
    .awready  (m_axi_awready),
    .wvalid   (m_axi_wvalid),
    .wdata    (m_axi_wdata),
    .wready   (m_axi_wready),
    .bvalid   (m_axi_bvalid),
    .bid      (m_axi_bid),
    .bresp    (m_axi_bresp),
    .bready   (m_axi_bready),
    .err_req  (err_req),
    .log_valid(log_valid),
    .log_addr (log_addr),
    .log_data (log_data)
  );

  always #2 clk = ~clk;

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    assert (got === want) else begin
      $display("Fail %s: got %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  // row-major, one address per pixel.
  function automatic fb_index_t pixel_index(input h_coord_t x, input v_coord_t y,
                                            input h_coord_t width);
    int unsigned idx;
    idx = y * width + x;
    return fb_index_t'(idx);
  endfunction

  // slave answers the oldest pending write.
  task automatic update_err_req();
    err_req = (exp_q.size() > 0) ? exp_q[0].err : 1'b0;
  endtask

  // x, y, colour, on-screen, error response. screen is 320 x 240.
  task automatic load_table();
    stim[0]  = {12'd0,    12'd0,    12'habc, 1'b1, 1'b0};
    stim[1]  = {12'd0,    12'd1,    12'h123, 1'b1, 1'b0}; // index is the width.
    stim[2]  = {12'd319,  12'd239,  12'hfff, 1'b1, 1'b0};
    stim[3]  = {12'd320,  12'd5,    12'h111, 1'b0, 1'b0};
    stim[4]  = {12'd10,   12'd240,  12'h222, 1'b0, 1'b0};
    stim[5]  = {12'd100,  12'd50,   12'h555, 1'b1, 1'b1}; // slverr from slave.
    stim[6]  = {12'd4095, 12'd4095, 12'h333, 1'b0, 1'b0};
    stim[7]  = {12'd5,    12'd5,    12'h777, 1'b1, 1'b0};
    stim[8]  = {12'd319,  12'd0,    12'h0a5, 1'b1, 1'b0};
    stim[9]  = {12'd600,  12'd3,    12'h444, 1'b0, 1'b0};
    stim[10] = {12'd1,    12'd239,  12'hf0f, 1'b1, 1'b0};
    stim[11] = {12'd2,    12'd2,    12'hc3c, 1'b1, 1'b0};
  endtask

  // entered 1 unit after an edge, leaves the same way.
  task automatic apply_pixel(input stim_s entry);
    expect_s want;
    s_gfx_valid       = 1'b1;
    s_gfx_pixel.x     = entry.x;
    s_gfx_pixel.y     = entry.y;
    s_gfx_pixel.pixel = entry.colour;
    if (entry.on_screen) begin
      want.addr = pixel_index(entry.x, entry.y, h_visible);
      want.data = data_width'(entry.colour);
      want.err  = entry.err;
      exp_q.push_back(want);
      err_expected = err_expected || entry.err;
      update_err_req();
    end
    @(negedge clk);
    while (!s_gfx_ready) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  // each response closes the oldest on-screen pixel.
  always @(posedge clk) begin
    if (log_valid) begin
      assert (exp_q.size() > 0) else begin
        $display("unexpected write to address %h with no on-screen pixel pending", log_addr);
        errors++;
      end
      if (exp_q.size() > 0) begin
        head       = exp_q.pop_front();
        err_so_far = err_so_far || head.err;
        compare_value("m_axi_awaddr", log_addr, head.addr);
        compare_value("m_axi_wdata", log_data, head.data);
        compare_value("resp_error", resp_error, err_so_far);
        update_err_req();
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      aw_wait = 1'b0;
      w_wait  = 1'b0;
    end else begin
      if (aw_wait) begin // stalled beat must hold.
        compare_value("m_axi_awvalid", m_axi_awvalid, 1);
        compare_value("m_axi_awaddr", m_axi_awaddr, aw_held);
      end
      if (w_wait) begin
        compare_value("m_axi_wvalid", m_axi_wvalid, 1);
        compare_value("m_axi_wdata", m_axi_wdata, w_held);
      end
      if (m_axi_awvalid && m_axi_awready) begin
        compare_value("m_axi_awid", m_axi_awid, write_id);
        compare_value("m_axi_awlen", m_axi_awlen, 0);
        compare_value("m_axi_awsize", m_axi_awsize, 1); // two bytes per beat.
        compare_value("m_axi_awburst", m_axi_awburst, 1);
      end
      if (m_axi_wvalid && m_axi_wready) begin
        compare_value("m_axi_wstrb", m_axi_wstrb, {(data_width/8){1'b1}});
        compare_value("m_axi_wlast", m_axi_wlast, 1);
      end
      aw_wait = m_axi_awvalid && !m_axi_awready;
      aw_held = m_axi_awaddr;
      w_wait  = m_axi_wvalid && !m_axi_wready;
      w_held  = m_axi_wdata;
    end
  end

  initial begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: pixel writes did not complete within %0d cycles", limit_cycles);
    errors++;
    $display("errors: %0d", errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    s_gfx_valid  = 1'b0;
    s_gfx_pixel  = '0;
    h_visible    = 12'd320;
    v_visible    = 12'd240;
    err_req      = 1'b0;
    errors       = 0;
    err_so_far   = 1'b0;
    err_expected = 1'b0;
    load_table();
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    compare_value("m_axi_awvalid", m_axi_awvalid, 0);
    compare_value("m_axi_wvalid", m_axi_wvalid, 0);
    compare_value("m_axi_bready", m_axi_bready, 0);
    compare_value("s_gfx_ready", s_gfx_ready, 1);
    compare_value("resp_error", resp_error, 0);
    @(posedge clk);
    #1;
    for (int i = 0; i < num_entries; i++) begin
      apply_pixel(stim[i]);
    end
    s_gfx_valid = 1'b0;
    while (exp_q.size() > 0) @(negedge clk);
    repeat (20) @(posedge clk); // room for any stray write.
    compare_value("resp_error", resp_error, err_expected);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== files.f ====
src/fb_pkg.sv
src/fb_clip.sv
src/fb_addr_gen.sv
src/fb_axi_writer.sv
src/gfx_fb_writer.sv
verification/fb_axi_slave_model.sv
verification/gfx_fb_writer_tb.sv
